// File: hw/rv_pkg.sv
package rv_pkg;

    // datapath width and state after reset
    localparam int xlen = 32;
    localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;
    // add x0, x0, x0
    localparam logic [31:0] nop_instr = 32'h0000_0033;

    // major opcodes
    localparam logic [6:0] opc_lui       = 7'b0110111;
    localparam logic [6:0] opc_auipc     = 7'b0010111;
    localparam logic [6:0] opc_jal       = 7'b1101111;
    localparam logic [6:0] opc_jalr      = 7'b1100111;
    localparam logic [6:0] opc_branch    = 7'b1100011;
    localparam logic [6:0] opc_load      = 7'b0000011;
    localparam logic [6:0] opc_store     = 7'b0100011;
    localparam logic [6:0] opc_ari_itype = 7'b0010011;
    localparam logic [6:0] opc_ari_rtype = 7'b0110011;

    // branch conditions
    localparam logic [2:0] fnc_beq  = 3'b000;
    localparam logic [2:0] fnc_bne  = 3'b001;
    localparam logic [2:0] fnc_blt  = 3'b100;
    localparam logic [2:0] fnc_bge  = 3'b101;
    localparam logic [2:0] fnc_bltu = 3'b110;
    localparam logic [2:0] fnc_bgeu = 3'b111;
    // load widths, bit 2 selects zero extension
    localparam logic [2:0] fnc_lb  = 3'b000;
    localparam logic [2:0] fnc_lh  = 3'b001;
    localparam logic [2:0] fnc_lw  = 3'b010;
    localparam logic [2:0] fnc_lbu = 3'b100;
    localparam logic [2:0] fnc_lhu = 3'b101;
    // store widths
    localparam logic [2:0] fnc_sb = 3'b000;
    localparam logic [2:0] fnc_sh = 3'b001;
    localparam logic [2:0] fnc_sw = 3'b010;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
        alu_srl, alu_sra, alu_or, alu_and, alu_copy_a
    } alu_op_t;

    // four field layouts of the same instruction word
    typedef struct packed {
        logic [6:0] funct7; logic [4:0] rs2; logic [4:0] rs1;
        logic [2:0] funct3; logic [4:0] rd; logic [6:0] opcode;
    } r_view_t;
    typedef struct packed {
        logic [11:0] imm12; logic [4:0] rs1; logic [2:0] funct3;
        logic [4:0] rd; logic [6:0] opcode;
    } i_view_t;
    typedef struct packed {
        logic [6:0] imm_hi; logic [4:0] rs2; logic [4:0] rs1;
        logic [2:0] funct3; logic [4:0] imm_lo; logic [6:0] opcode;
    } s_view_t;
    typedef struct packed {
        logic [19:0] imm20; logic [4:0] rd; logic [6:0] opcode;
    } u_view_t;
    typedef union packed {
        r_view_t r; i_view_t i; s_view_t s; u_view_t u;
    } instr_u;

    typedef struct packed {
        logic valid; logic [xlen-1:0] pc; instr_u instr; logic [xlen-1:0] rs1_val;
        logic [xlen-1:0] rs2_val; logic [xlen-1:0] imm; alu_op_t alu_op;
    } fd_ex_t;
    typedef struct packed {
        logic valid; logic [xlen-1:0] pc; instr_u instr; logic [xlen-1:0] alu_res;
        logic [xlen-1:0] st_data; logic [3:0] sel; logic taken; logic [xlen-1:0] target;
    } ex_mw_t;
    typedef struct packed {
        logic we; logic [4:0] rd; logic [xlen-1:0] data;
    } wb_write_t;
    typedef struct packed {
        logic valid; logic [xlen-1:0] target;
    } redirect_t;
    // wishbone classic master and slave sides
    typedef struct packed {
        logic cyc; logic stb; logic we; logic [xlen-1:0] adr; logic [xlen-1:0] dat;
        logic [3:0] sel;
    } wb_req_t;
    typedef struct packed {
        logic ack; logic [xlen-1:0] dat;
    } wb_rsp_t;

endpackage

// File: hw/reg_file.sv
`timescale 1ns/1ps
module reg_file import rv_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic [4:0]      ra1,
    input  logic [4:0]      ra2,
    input  wb_write_t       wr,
    output logic [xlen-1:0] rd1,
    output logic [xlen-1:0] rd2
);
    // x1..x31 only, x0 has no storage
    logic [xlen-1:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.we && wr.rd != 5'd0) begin
            regs[wr.rd] <= wr.data;
        end
    end

    // combinational reads
    assign rd1 = (ra1 == 5'd0) ? '0 : regs[ra1];
    assign rd2 = (ra2 == 5'd0) ? '0 : regs[ra2];

endmodule

// File: hw/fetch_decode.sv
`timescale 1ns/1ps
module fetch_decode import rv_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic [xlen-1:0] imem_rdata,
    input  logic [xlen-1:0] rf_rd1,
    input  logic [xlen-1:0] rf_rd2,
    input  wb_write_t       wr,
    input  redirect_t       redirect,
    input  logic            stall,
    output logic [xlen-1:0] imem_addr,
    output logic [4:0]      rf_ra1,
    output logic [4:0]      rf_ra2,
    output fd_ex_t          fd_ex
);
    logic [xlen-1:0] pc_q;
    logic [xlen-1:0] pc_d;
    logic            fetch_valid;
    instr_u          instr;
    logic [6:0]      opc;
    logic [6:0]      ex_opc;
    logic            uses_rs1;
    logic            uses_rs2;
    logic            ctrl_in_ex;
    logic            dep_in_ex;
    logic            hold;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] rs1_val;
    logic [xlen-1:0] rs2_val;
    alu_op_t         alu_op;
    fd_ex_t          fd_ex_d;

    assign instr  = imem_rdata;
    assign opc    = instr.r.opcode;
    assign ex_opc = fd_ex.instr.r.opcode;

    // control ops and loads in stage 2 always cost a bubble
    assign ctrl_in_ex = fd_ex.valid && (ex_opc inside {opc_jal, opc_jalr, opc_branch, opc_load});
    assign uses_rs1 = !(opc inside {opc_lui, opc_auipc, opc_jal});
    assign uses_rs2 = opc inside {opc_ari_rtype, opc_store, opc_branch};
    // alu result not yet in the register file
    assign dep_in_ex = fd_ex.valid && fd_ex.instr.r.rd != 5'd0
        && (ex_opc inside {opc_ari_rtype, opc_ari_itype, opc_lui, opc_auipc})
        && ((uses_rs1 && instr.r.rs1 == fd_ex.instr.r.rd)
            || (uses_rs2 && instr.r.rs2 == fd_ex.instr.r.rd));
    // first cycle out of reset has no fetched word yet
    assign hold = !fetch_valid || ctrl_in_ex || dep_in_ex;

    // next fetch address, freeze wins over redirect
    always_comb begin
        if (stall || (!redirect.valid && hold)) begin
            pc_d = pc_q;
        end else if (redirect.valid) begin
            pc_d = redirect.target;
        end else begin
            pc_d = pc_q + 32'd4;
        end
    end
    assign imem_addr = pc_d;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc_q        <= reset_pc;
            fetch_valid <= 1'b0;
        end else begin
            pc_q        <= pc_d;
            fetch_valid <= 1'b1;
        end
    end

    // immediate per format
    always_comb begin
        case (opc)
            opc_ari_itype, opc_load, opc_jalr:
                imm = {{20{instr.i.imm12[11]}}, instr.i.imm12};
            opc_store:
                imm = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
            opc_branch:
                imm = {{19{instr.s.imm_hi[6]}}, instr.s.imm_hi[6], instr.s.imm_lo[0],
                       instr.s.imm_hi[5:0], instr.s.imm_lo[4:1], 1'b0};
            opc_lui, opc_auipc:
                imm = {instr.u.imm20, 12'd0};
            opc_jal:
                imm = {{11{instr.u.imm20[19]}}, instr.u.imm20[19], instr.u.imm20[7:0],
                       instr.u.imm20[8], instr.u.imm20[18:9], 1'b0};
            default:
                imm = '0;
        endcase
    end

    // register reads, stage-3 write bypassed in
    assign rf_ra1  = instr.r.rs1;
    assign rf_ra2  = instr.r.rs2;
    assign rs1_val = (wr.we && wr.rd != 5'd0 && wr.rd == instr.r.rs1) ? wr.data : rf_rd1;
    assign rs2_val = (wr.we && wr.rd != 5'd0 && wr.rd == instr.r.rs2) ? wr.data : rf_rd2;

    // alu op, funct7 bit 5 picks sub and sra
    always_comb begin
        alu_op = alu_add;
        if (opc == opc_lui) begin
            alu_op = alu_copy_a;
        end else if (opc == opc_ari_rtype || opc == opc_ari_itype) begin
            case (instr.r.funct3)
                3'b000:  alu_op = (opc == opc_ari_rtype && instr.r.funct7[5]) ? alu_sub : alu_add;
                3'b001:  alu_op = alu_sll;
                3'b010:  alu_op = alu_slt;
                3'b011:  alu_op = alu_sltu;
                3'b100:  alu_op = alu_xor;
                3'b101:  alu_op = instr.r.funct7[5] ? alu_sra : alu_srl;
                3'b110:  alu_op = alu_or;
                default: alu_op = alu_and;
            endcase
        end
    end

    always_comb begin
        fd_ex_d.valid   = !(redirect.valid || hold);
        fd_ex_d.pc      = pc_q;
        fd_ex_d.instr   = fd_ex_d.valid ? instr : instr_u'(nop_instr);
        // lui reads no register, its operand a carries the immediate
        fd_ex_d.rs1_val = (opc == opc_lui) ? imm : rs1_val;
        fd_ex_d.rs2_val = rs2_val;
        fd_ex_d.imm     = imm;
        fd_ex_d.alu_op  = alu_op;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fd_ex.valid <= 1'b0;
        end else if (!stall) begin
            fd_ex <= fd_ex_d;
        end
    end

    pc_word_aligned: assert property (@(posedge clk) disable iff (reset) pc_q[1:0] == 2'b00);

endmodule

// File: hw/execute.sv
`timescale 1ns/1ps
module execute import rv_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  fd_ex_t fd_ex,
    input  logic   stall,
    output ex_mw_t ex_mw
);
    logic [6:0]      opc;
    logic [2:0]      funct3;
    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [4:0]      shamt;
    logic [xlen-1:0] alu_res;
    logic            eq;
    logic            lt;
    logic            ltu;
    logic            taken;
    logic [xlen-1:0] target;
    logic [xlen-1:0] st_data;
    logic [3:0]      sel;
    ex_mw_t          ex_mw_d;

    assign opc    = fd_ex.instr.r.opcode;
    assign funct3 = fd_ex.instr.r.funct3;

    // operand a is pc only for auipc and jal
    assign op_a  = (opc == opc_auipc || opc == opc_jal) ? fd_ex.pc : fd_ex.rs1_val;
    // register operand b for r-type and the branch compare
    assign op_b  = (opc == opc_ari_rtype || opc == opc_branch) ? fd_ex.rs2_val : fd_ex.imm;
    assign shamt = op_b[4:0];

    always_comb begin
        case (fd_ex.alu_op)
            alu_add:  alu_res = op_a + op_b;
            alu_sub:  alu_res = op_a - op_b;
            alu_sll:  alu_res = op_a << shamt;
            alu_slt:  alu_res = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            alu_sltu: alu_res = {{(xlen-1){1'b0}}, op_a < op_b};
            alu_xor:  alu_res = op_a ^ op_b;
            alu_srl:  alu_res = op_a >> shamt;
            alu_sra:  alu_res = $signed(op_a) >>> shamt;
            alu_or:   alu_res = op_a | op_b;
            alu_and:  alu_res = op_a & op_b;
            default:  alu_res = op_a;
        endcase
    end

    // branch compare on raw register values
    assign eq  = fd_ex.rs1_val == fd_ex.rs2_val;
    assign lt  = $signed(fd_ex.rs1_val) < $signed(fd_ex.rs2_val);
    assign ltu = fd_ex.rs1_val < fd_ex.rs2_val;

    always_comb begin
        taken = 1'b0;
        if (opc == opc_jal || opc == opc_jalr) begin
            taken = 1'b1;
        end else if (opc == opc_branch) begin
            case (funct3)
                fnc_beq:  taken = eq;
                fnc_bne:  taken = !eq;
                fnc_blt:  taken = lt;
                fnc_bge:  taken = !lt;
                fnc_bltu: taken = ltu;
                fnc_bgeu: taken = !ltu;
                default:  taken = 1'b0;
            endcase
        end
    end

    // jalr target has bit 0 cleared
    assign target = (opc == opc_jalr) ? ((fd_ex.rs1_val + fd_ex.imm) & ~32'd1)
                                      : (fd_ex.pc + fd_ex.imm);

    // byte lanes from width and address low bits, loads reuse sel
    always_comb begin
        case (funct3[1:0])
            fnc_sb[1:0]: begin
                st_data = {4{fd_ex.rs2_val[7:0]}};
                sel     = 4'b0001 << alu_res[1:0];
            end
            fnc_sh[1:0]: begin
                st_data = {2{fd_ex.rs2_val[15:0]}};
                sel     = alu_res[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                st_data = fd_ex.rs2_val;
                sel     = 4'b1111;
            end
        endcase
    end

    always_comb begin
        ex_mw_d.valid   = fd_ex.valid;
        ex_mw_d.pc      = fd_ex.pc;
        ex_mw_d.instr   = fd_ex.instr;
        ex_mw_d.alu_res = alu_res;
        ex_mw_d.st_data = st_data;
        ex_mw_d.sel     = sel;
        ex_mw_d.taken   = taken;
        ex_mw_d.target  = target;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_mw.valid <= 1'b0;
        end else if (!stall) begin
            ex_mw <= ex_mw_d;
        end
    end

    // half and word stores stay inside one bus word
    store_aligned: assert property (
        @(posedge clk) disable iff (reset)
        (ex_mw.valid && ex_mw.instr.s.opcode == opc_store) |->
        ((ex_mw.instr.s.funct3 == fnc_sh) ? (ex_mw.alu_res[0] == 1'b0) :
         (ex_mw.instr.s.funct3 == fnc_sw) ? (ex_mw.alu_res[1:0] == 2'b00) : 1'b1)
    );

endmodule

// File: hw/mem_writeback.sv
`timescale 1ns/1ps
module mem_writeback import rv_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  ex_mw_t    ex_mw,
    input  wb_rsp_t   wb_rsp,
    output wb_req_t   wb_req,
    output wb_write_t wr,
    output redirect_t redirect,
    output logic      stall
);
    logic [6:0]      opc;
    logic [2:0]      funct3;
    logic            is_load;
    logic            is_store;
    logic            is_mem;
    logic            is_jump;
    logic            writes_rd;
    logic [xlen-1:0] rdata_sh;
    logic [xlen-1:0] load_val;
    logic [xlen-1:0] wb_data;

    assign opc      = ex_mw.instr.r.opcode;
    assign funct3   = ex_mw.instr.r.funct3;
    assign is_load  = ex_mw.valid && opc == opc_load;
    assign is_store = ex_mw.valid && opc == opc_store;
    assign is_mem   = is_load || is_store;
    assign is_jump  = opc == opc_jal || opc == opc_jalr;

    // one classic cycle per load or store, held until ack
    always_comb begin
        wb_req.cyc = is_mem;
        wb_req.stb = is_mem;
        wb_req.we  = is_store;
        wb_req.adr = {ex_mw.alu_res[xlen-1:2], 2'b00};
        wb_req.dat = ex_mw.st_data;
        wb_req.sel = ex_mw.sel;
    end

    // whole pipeline waits on the bus
    assign stall = is_mem && !wb_rsp.ack;

    // addressed lane moved down to bit 0
    assign rdata_sh = wb_rsp.dat >> {ex_mw.alu_res[1:0], 3'b000};

    always_comb begin
        case (funct3)
            fnc_lb:  load_val = {{24{rdata_sh[7]}}, rdata_sh[7:0]};
            fnc_lh:  load_val = {{16{rdata_sh[15]}}, rdata_sh[15:0]};
            fnc_lbu: load_val = {24'd0, rdata_sh[7:0]};
            fnc_lhu: load_val = {16'd0, rdata_sh[15:0]};
            fnc_lw:  load_val = rdata_sh;
            default: load_val = rdata_sh;
        endcase
    end

    // link value for jumps, loaded value, otherwise alu
    always_comb begin
        if (is_load) begin
            wb_data = load_val;
        end else if (is_jump) begin
            wb_data = ex_mw.pc + 32'd4;
        end else begin
            wb_data = ex_mw.alu_res;
        end
    end

    // stores and branches have no rd
    assign writes_rd = ex_mw.valid && !(opc inside {opc_store, opc_branch});

    // a load writes only in its ack cycle
    always_comb begin
        wr.we   = writes_rd && !stall;
        wr.rd   = ex_mw.instr.r.rd;
        wr.data = wb_data;
    end

    always_comb begin
        redirect.valid  = ex_mw.valid && ex_mw.taken;
        redirect.target = ex_mw.target;
    end

    // request stays up and unchanged until acked
    req_held_to_ack: assert property (
        @(posedge clk) disable iff (reset)
        (wb_req.stb && !wb_rsp.ack) |=> (wb_req.stb && $stable(wb_req.adr))
    );

endmodule

// File: hw/rv_core.sv
`timescale 1ns/1ps
module rv_core import rv_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic [xlen-1:0] imem_rdata,
    input  wb_rsp_t         wb_rsp,
    output logic [xlen-1:0] imem_addr,
    output wb_req_t         wb_req
);
    logic [4:0]      rf_ra1;
    logic [4:0]      rf_ra2;
    logic [xlen-1:0] rf_rd1;
    logic [xlen-1:0] rf_rd2;
    fd_ex_t          fd_ex;
    ex_mw_t          ex_mw;
    wb_write_t       wr;
    redirect_t       redirect;
    logic            stall;

    // stage 1, fetch and decode
    fetch_decode u_fetch_decode (
        .clk(clk), .reset(reset),
        .imem_rdata(imem_rdata), .rf_rd1(rf_rd1), .rf_rd2(rf_rd2),
        .wr(wr), .redirect(redirect), .stall(stall),
        .imem_addr(imem_addr), .rf_ra1(rf_ra1), .rf_ra2(rf_ra2),
        .fd_ex(fd_ex)
    );

    // written from stage 3, read in stage 1
    reg_file u_reg_file (
        .clk(clk), .reset(reset),
        .ra1(rf_ra1), .ra2(rf_ra2), .wr(wr),
        .rd1(rf_rd1), .rd2(rf_rd2)
    );

    // stage 2
    execute u_execute (
        .clk(clk), .reset(reset),
        .fd_ex(fd_ex), .stall(stall),
        .ex_mw(ex_mw)
    );

    // stage 3, wishbone access and write-back
    mem_writeback u_mem_writeback (
        .clk(clk), .reset(reset),
        .ex_mw(ex_mw), .wb_rsp(wb_rsp),
        .wb_req(wb_req), .wr(wr), .redirect(redirect), .stall(stall)
    );

endmodule

// File: dv/rv_checker.sv
`timescale 1ns/1ps
module rv_checker import rv_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  wb_req_t     wb_req,
    input  wb_rsp_t     wb_rsp,
    input  logic [31:0] exp_adr [0:31],
    input  logic [31:0] exp_dat [0:31],
    input  logic [3:0]  exp_sel [0:31],
    input  int          exp_n,
    output int          seen,
    output int          val_errs,
    output int          proto_errs
);
    // request captured while the slave is still waiting
    wb_req_t held;
    logic    waiting;

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("** Error %s: expected %h, got %h", name, exp, act);
            val_errs++;
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            seen       <= 0;
            val_errs   = 0;
            proto_errs = 0;
            waiting    <= 1'b0;
        end else begin
            // classic bus rule, fields frozen until ack
            if (waiting && wb_req !== held) begin
                $display("request fields changed before ack at %0t", $time);
                proto_errs++;
            end
            waiting <= wb_req.stb && !wb_rsp.ack;
            held    <= wb_req;
            if (wb_req.cyc && wb_req.stb && wb_rsp.ack && wb_req.we) begin
                if (seen >= exp_n) begin
                    $display("unexpected extra store to address %h", wb_req.adr);
                    proto_errs++;
                end else begin
                    check_val("wb_req.adr", exp_adr[seen], wb_req.adr);
                    check_val("wb_req.dat", exp_dat[seen], wb_req.dat);
                    check_val("wb_req.sel", {28'd0, exp_sel[seen]}, {28'd0, wb_req.sel});
                end
                seen <= seen + 1;
            end
        end
    end

endmodule

// File: dv/tb_rv_core.sv
`timescale 1ns/1ps
module tb_rv_core import rv_pkg::*; ();
    typedef struct packed {
        logic [31:0] ins; logic chk; logic [31:0] adr; logic [31:0] dat; logic [3:0] sel;
    } row_t;

    logic        clk = 1'b0;
    logic        reset = 1'b1;
    logic [31:0] imem_rdata = nop_instr;
    wb_rsp_t     wb_rsp = '0;
    logic [31:0] imem_addr;
    wb_req_t     wb_req;
    logic [31:0] imem [0:63];
    logic [31:0] dmem [0:63];
    logic [31:0] preload [0:1];
    logic [31:0] exp_adr [0:31];
    logic [31:0] exp_dat [0:31];
    logic [3:0]  exp_sel [0:31];
    int          exp_n = 0;
    int          seen;
    int          val_errs;
    int          proto_errs;
    int          dly;
    row_t        rows [$];

    always #2 clk = ~clk;

    rv_core u_dut (.clk(clk), .reset(reset), .imem_rdata(imem_rdata), .wb_rsp(wb_rsp),
                   .imem_addr(imem_addr), .wb_req(wb_req));

    rv_checker u_chk (.clk(clk), .reset(reset), .wb_req(wb_req), .wb_rsp(wb_rsp),
                      .exp_adr(exp_adr), .exp_dat(exp_dat), .exp_sel(exp_sel), .exp_n(exp_n),
                      .seen(seen), .val_errs(val_errs), .proto_errs(proto_errs));

    // small assembler for the program table
    function automatic logic [31:0] enc_r(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd,
                                          logic [4:0] rs1, logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, opc_ari_rtype};
    endfunction
    function automatic logic [31:0] enc_i(logic [2:0] f3, logic [4:0] rd, logic [4:0] rs1,
                                          logic [11:0] imm, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction
    function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs1, logic [4:0] rs2,
                                          logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], opc_store};
    endfunction
    function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs1, logic [4:0] rs2,
                                          logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc_branch};
    endfunction
    function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc_jal};
    endfunction
    function automatic logic [31:0] sw_of(logic [4:0] rs, logic [11:0] off);
        return enc_s(off, 5'd0, rs, fnc_sw);
    endfunction

    task automatic add_row(logic [31:0] ins, logic chk, logic [31:0] adr, logic [31:0] dat,
                           logic [3:0] sel);
        rows.push_back({ins, chk, adr, dat, sel});
    endtask

    // instruction port, one cycle read latency
    always @(posedge clk) begin
        imem_rdata <= imem[imem_addr[7:2]];
    end

    // wishbone slave with 1 to 4 wait cycles
    always @(posedge clk) begin
        if (reset) begin
            wb_rsp <= '0;
            dly    <= 0;
            for (int i = 0; i < 64; i++) begin
                dmem[i] <= (i < 2) ? preload[i] : (32'hA5C3_0000 ^ (i * 32'h0101_0111));
            end
        end else begin
            wb_rsp.ack <= 1'b0;
            if (wb_req.stb && !wb_rsp.ack) begin
                if (dly == 0) begin
                    dly <= $urandom_range(1, 4);
                end else if (dly == 1) begin
                    dly        <= 0;
                    wb_rsp.ack <= 1'b1;
                    wb_rsp.dat <= dmem[wb_req.adr[7:2]];
                    for (int b = 0; b < 4; b++) begin
                        if (wb_req.we && wb_req.sel[b]) begin
                            dmem[wb_req.adr[7:2]][8*b +: 8] <= wb_req.dat[8*b +: 8];
                        end
                    end
                end else begin
                    dly <= dly - 1;
                end
            end
        end
    end

    initial begin
        logic [31:0] shadow;
        int          cyc;
        void'($urandom(32'hc42063dd));
        preload[0] = 32'h80F1_7F55;
        preload[1] = 32'h1234_5678;
        // store in a skipped slot, never expected on the bus
        shadow = sw_of(5'd1, 12'h0F0);
        add_row(enc_i(3'b000, 1, 0, 12'h123, opc_ari_itype), 0, 0, 0, 0);
        add_row(enc_i(3'b000, 2, 0, 12'hFFB, opc_ari_itype), 0, 0, 0, 0);
        add_row(enc_r(7'h00, 3'b000, 3, 1, 2), 0, 0, 0, 0);
        add_row(sw_of(3, 12'h080), 1, 32'h80, 32'h123 + 32'hFFFF_FFFB, 4'hF);
        add_row(enc_r(7'h20, 3'b000, 4, 1, 2), 0, 0, 0, 0);
        add_row(sw_of(4, 12'h084), 1, 32'h84, 32'h123 - 32'hFFFF_FFFB, 4'hF);
        add_row(enc_r(7'h00, 3'b100, 5, 1, 2), 0, 0, 0, 0);
        add_row(sw_of(5, 12'h088), 1, 32'h88, 32'h123 ^ 32'hFFFF_FFFB, 4'hF);
        add_row(enc_i(3'b101, 6, 2, 12'h401, opc_ari_itype), 0, 0, 0, 0);
        add_row(sw_of(6, 12'h08C), 1, 32'h8C, 32'hFFFF_FFFD, 4'hF);
        add_row(enc_r(7'h00, 3'b010, 7, 2, 1), 0, 0, 0, 0);
        add_row(sw_of(7, 12'h090), 1, 32'h90, 32'h1, 4'hF);
        add_row(enc_r(7'h00, 3'b011, 8, 2, 1), 0, 0, 0, 0);
        add_row(sw_of(8, 12'h094), 1, 32'h94, 32'h0, 4'hF);
        add_row({20'hABCDE, 5'd9, opc_lui}, 0, 0, 0, 0);
        add_row({20'h00001, 5'd10, opc_auipc}, 0, 0, 0, 0);
        add_row(sw_of(9, 12'h098), 1, 32'h98, 32'hABCD_E000, 4'hF);
        add_row(sw_of(10, 12'h09C), 1, 32'h9C, 32'h3C + 32'h1000, 4'hF);
        add_row(enc_s(12'h0A1, 0, 1, fnc_sb), 1, 32'hA0, 32'h2323_2323, 4'b0010);
        add_row(enc_s(12'h0A6, 0, 2, fnc_sh), 1, 32'hA4, 32'hFFFB_FFFB, 4'b1100);
        add_row(enc_i(fnc_lb, 11, 0, 12'h002, opc_load), 0, 0, 0, 0);
        add_row(sw_of(11, 12'h0B0), 1, 32'hB0, 32'hFFFF_FFF1, 4'hF);
        add_row(enc_i(fnc_lhu, 12, 0, 12'h002, opc_load), 0, 0, 0, 0);
        add_row(sw_of(12, 12'h0B4), 1, 32'hB4, 32'h0000_80F1, 4'hF);
        add_row(enc_i(fnc_lw, 13, 0, 12'h004, opc_load), 0, 0, 0, 0);
        add_row(sw_of(13, 12'h0B8), 1, 32'hB8, 32'h1234_5678, 4'hF);
        add_row(enc_i(fnc_lh, 14, 0, 12'h002, opc_load), 0, 0, 0, 0);
        add_row(sw_of(14, 12'h0BC), 1, 32'hBC, 32'hFFFF_80F1, 4'hF);
        add_row(enc_i(fnc_lbu, 15, 0, 12'h002, opc_load), 0, 0, 0, 0);
        add_row(sw_of(15, 12'h0C0), 1, 32'hC0, 32'h0000_00F1, 4'hF);
        // not-taken branches, a wrong take lands on the first shadow store at 0x94
        add_row(enc_b(13'd28, 1, 2, fnc_beq), 0, 0, 0, 0);
        add_row(enc_b(13'd24, 1, 1, fnc_bne), 0, 0, 0, 0);
        add_row(enc_b(13'd20, 1, 2, fnc_blt), 0, 0, 0, 0);
        add_row(enc_b(13'd16, 2, 1, fnc_bge), 0, 0, 0, 0);
        add_row(enc_b(13'd12, 2, 1, fnc_bltu), 0, 0, 0, 0);
        add_row(enc_b(13'd8, 1, 2, fnc_bgeu), 0, 0, 0, 0);
        // taken branches, each skips one shadow store
        add_row(enc_b(13'd8, 1, 1, fnc_beq), 0, 0, 0, 0);
        add_row(shadow, 0, 0, 0, 0);
        add_row(enc_b(13'd8, 1, 2, fnc_bne), 0, 0, 0, 0);
        add_row(shadow, 0, 0, 0, 0);
        add_row(enc_b(13'd8, 2, 1, fnc_blt), 0, 0, 0, 0);
        add_row(shadow, 0, 0, 0, 0);
        add_row(enc_b(13'd8, 1, 2, fnc_bge), 0, 0, 0, 0);
        add_row(shadow, 0, 0, 0, 0);
        add_row(enc_b(13'd8, 1, 2, fnc_bltu), 0, 0, 0, 0);
        add_row(shadow, 0, 0, 0, 0);
        add_row(enc_b(13'd8, 2, 1, fnc_bgeu), 0, 0, 0, 0);
        add_row(shadow, 0, 0, 0, 0);
        // jal at pc 0xC0, link is pc+4
        add_row(enc_j(21'd8, 16), 0, 0, 0, 0);
        add_row(shadow, 0, 0, 0, 0);
        add_row(sw_of(16, 12'h0C4), 1, 32'hC4, 32'hC0 + 32'h4, 4'hF);
        // jalr at pc 0xD0 to 0xDD with bit 0 dropped
        add_row(enc_i(3'b000, 17, 0, 12'h0DD, opc_ari_itype), 0, 0, 0, 0);
        add_row(enc_i(3'b000, 18, 17, 12'h000, opc_jalr), 0, 0, 0, 0);
        add_row(shadow, 0, 0, 0, 0);
        add_row(shadow, 0, 0, 0, 0);
        add_row(sw_of(18, 12'h0C8), 1, 32'hC8, 32'hD0 + 32'h4, 4'hF);
        // remaining byte and half lanes
        add_row(enc_s(12'h0A8, 0, 1, fnc_sb), 1, 32'hA8, 32'h2323_2323, 4'b0001);
        add_row(enc_s(12'h0AE, 0, 1, fnc_sb), 1, 32'hAC, 32'h2323_2323, 4'b0100);
        add_row(enc_s(12'h0CF, 0, 1, fnc_sb), 1, 32'hCC, 32'h2323_2323, 4'b1000);
        add_row(enc_s(12'h0D0, 0, 2, fnc_sh), 1, 32'hD0, 32'hFFFB_FFFB, 4'b0011);
        add_row(enc_j(21'd0, 0), 0, 0, 0, 0);

        for (int i = 0; i < 64; i++) begin
            imem[i] = (i < rows.size()) ? rows[i].ins : enc_j(21'd0, 0);
        end
        foreach (rows[i]) begin
            if (rows[i].chk) begin
                exp_adr[exp_n] = rows[i].adr;
                exp_dat[exp_n] = rows[i].dat;
                exp_sel[exp_n] = rows[i].sel;
                exp_n++;
            end
        end

        repeat (5) @(posedge clk);
        reset <= 1'b0;
        cyc = 0;
        while (seen < exp_n && cyc < 4000) begin
            @(posedge clk);
            cyc++;
        end
        // tail of the jal loop, catches late stray stores
        cyc = 0;
        while (cyc < 50) begin
            @(posedge clk);
            cyc++;
        end
        if (seen < exp_n) begin
            $display("timeout waiting for stores, %0d of %0d seen", seen, exp_n);
        end
        $display("value errors %0d, protocol errors %0d, stores %0d of %0d",
                 val_errs, proto_errs, seen, exp_n);
        if (val_errs == 0 && proto_errs == 0 && seen == exp_n) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: rv_core.f
hw/rv_pkg.sv
hw/reg_file.sv
hw/fetch_decode.sv
hw/execute.sv
hw/mem_writeback.sv
hw/rv_core.sv
dv/rv_checker.sv
dv/tb_rv_core.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_rv_core -f rv_core.f \
    --Mdir obj_dir -o sim_rv_core

out=$(./obj_dir/sim_rv_core)
echo "$out"

if grep -q "ALL TESTS PASSED" <<< "$out"; then
    exit 0
else
    exit 1
fi
